//--- verilog/bsr_macros.svh
`ifndef BSR_MACROS_SVH
`define BSR_MACROS_SVH

// image geometry
`define BSR_ROW_BITS 64
`define BSR_WORD_BITS 32
`define BSR_WORDS_PER_ROW 2

// row number, 64 rows
`define BSR_ROW_AW 6

// word address into the image memory
`define BSR_MEM_AW 7

// column index within a row
`define BSR_COL_W 6

// gap counter and its limit
`define BSR_GAP_W 4

`endif

//--- verilog/bsr_pkg.sv
`include "bsr_macros.svh"
`default_nettype none

package bsr_pkg;

	typedef logic [`BSR_ROW_AW-1:0] row_num_t;
	typedef logic [`BSR_ROW_BITS-1:0] row_bits_t;
	typedef logic [`BSR_COL_W-1:0] col_idx_t;
	typedef logic [`BSR_GAP_W-1:0] gap_t;
	typedef logic [`BSR_MEM_AW-1:0] mem_addr_t;
	typedef logic [`BSR_WORD_BITS-1:0] mem_word_t;

	// stable while i_trig is high
	typedef struct packed {
		row_num_t first_row;
		row_num_t last_row;
		gap_t max_gap;
	} bsr_cfg_t;

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		mem_addr_t adr;
		mem_word_t dat;
	} wb_req_t;

	typedef struct packed {
		logic ack;
		mem_word_t dat;
	} wb_rsp_t;

	// fetch to scan
	typedef struct packed {
		row_num_t row;
		logic first;
		logic last;
		row_bits_t bits;
	} row_item_t;

	// scan to write-back
	typedef struct packed {
		row_num_t row;
		logic last;
		row_bits_t bits;
	} out_item_t;

	typedef enum logic [1:0] {
		FETCH_IDLE,
		FETCH_READ,
		FETCH_HOLD,
		FETCH_DRAIN
	} fetch_state_t;

	typedef enum logic [2:0] {
		SCAN_IDLE,
		SCAN_SEEK,
		SCAN_TRACK,
		SCAN_CLOSED,
		SCAN_MASK,
		SCAN_OUT
	} scan_state_t;

	typedef enum logic {
		WB_IDLE,
		WB_WRITE
	} wb_state_t;

endpackage

`default_nettype wire

//--- verilog/row_fetch.sv
`include "bsr_macros.svh"
`default_nettype none

module row_fetch (
	input wire logic i_clk,
	input wire logic i_rstn,
	input wire logic i_trig,
	input wire bsr_pkg::bsr_cfg_t i_cfg,
	output bsr_pkg::row_item_t o_item,
	output logic o_row_valid,
	input wire logic i_row_ready,
	output bsr_pkg::wb_req_t o_wb,
	input wire bsr_pkg::wb_rsp_t i_wb
);

	localparam int WIDX_W = $clog2(`BSR_WORDS_PER_ROW);
	localparam logic [WIDX_W-1:0] LAST_WORD = WIDX_W'(`BSR_WORDS_PER_ROW - 1);

	bsr_pkg::fetch_state_t state;
	bsr_pkg::row_num_t row_cnt;
	bsr_pkg::row_bits_t row_buf;
	logic [WIDX_W-1:0] word_cnt;
	logic first_flag;
	logic trig_q;

	always_ff @(posedge i_clk or negedge i_rstn)
	begin
		if (!i_rstn)
		begin
			state <= bsr_pkg::FETCH_IDLE;
			row_cnt <= '0;
			word_cnt <= '0;
			first_flag <= 1'b0;
			trig_q <= 1'b0;
		end
		else
		begin
			trig_q <= i_trig;
			case (state)
				bsr_pkg::FETCH_IDLE:
				begin
					// start only on a rising trig
					if (i_trig && !trig_q)
					begin
						row_cnt <= i_cfg.first_row;
						word_cnt <= '0;
						first_flag <= 1'b1;
						state <= bsr_pkg::FETCH_READ;
					end
				end
				bsr_pkg::FETCH_READ:
				begin
					if (i_wb.ack)
					begin
						if (word_cnt == LAST_WORD)
							state <= bsr_pkg::FETCH_HOLD;
						else
							word_cnt <= word_cnt + 1'b1;
					end
				end
				bsr_pkg::FETCH_HOLD:
				begin
					if (i_row_ready)
					begin
						first_flag <= 1'b0;
						word_cnt <= '0;
						if (row_cnt == i_cfg.last_row)
							state <= bsr_pkg::FETCH_DRAIN;
						else
						begin
							row_cnt <= row_cnt + 1'b1;
							state <= bsr_pkg::FETCH_READ;
						end
					end
				end
				bsr_pkg::FETCH_DRAIN:
				begin
					// run finished, wait for the trig level to drop
					if (!i_trig)
						state <= bsr_pkg::FETCH_IDLE;
				end
				default:
					state <= bsr_pkg::FETCH_IDLE;
			endcase
		end
	end

	// word k of the row lands in bits k*32 upward
	always_ff @(posedge i_clk)
	begin
		if (state == bsr_pkg::FETCH_READ && i_wb.ack)
			row_buf[word_cnt*`BSR_WORD_BITS +: `BSR_WORD_BITS] <= i_wb.dat;
	end

	assign o_wb.cyc = (state == bsr_pkg::FETCH_READ);
	assign o_wb.stb = (state == bsr_pkg::FETCH_READ);
	assign o_wb.we = 1'b0;
	assign o_wb.adr = bsr_pkg::mem_addr_t'(row_cnt * `BSR_WORDS_PER_ROW)
		+ bsr_pkg::mem_addr_t'(word_cnt);
	assign o_wb.dat = '0;

	assign o_row_valid = (state == bsr_pkg::FETCH_HOLD);
	assign o_item = '{row: row_cnt, first: first_flag,
		last: (row_cnt == i_cfg.last_row), bits: row_buf};

endmodule

`default_nettype wire

//--- verilog/boundary_scan.sv
`include "bsr_macros.svh"
`default_nettype none

module boundary_scan (
	input wire logic i_clk,
	input wire logic i_rstn,
	input wire bsr_pkg::row_item_t i_item,
	input wire logic i_row_valid,
	output logic o_row_ready,
	input wire bsr_pkg::gap_t i_max_gap,
	output bsr_pkg::out_item_t o_item,
	output logic o_out_valid,
	input wire logic i_out_ready
);

	localparam bsr_pkg::row_bits_t ALL_ONES = '1;
	localparam bsr_pkg::col_idx_t LAST_COL = bsr_pkg::col_idx_t'(`BSR_ROW_BITS - 1);

	bsr_pkg::scan_state_t state;
	bsr_pkg::col_idx_t col;
	bsr_pkg::gap_t gap;
	logic found;

	bsr_pkg::row_bits_t raw_row;
	bsr_pkg::row_bits_t filt_sr;
	bsr_pkg::row_bits_t prev_mask;
	bsr_pkg::row_bits_t new_mask;
	bsr_pkg::row_bits_t out_bits;
	bsr_pkg::row_num_t cur_row;
	bsr_pkg::col_idx_t left_b;
	bsr_pkg::col_idx_t right_b;
	logic cur_last;
	logic cur_bit;

	// filtered row shifts right, column col sits in bit 0
	assign cur_bit = filt_sr[0];

	always_ff @(posedge i_clk or negedge i_rstn)
	begin
		if (!i_rstn)
		begin
			state <= bsr_pkg::SCAN_IDLE;
			col <= '0;
			gap <= '0;
			found <= 1'b0;
		end
		else
		begin
			case (state)
				bsr_pkg::SCAN_IDLE:
				begin
					if (i_row_valid)
					begin
						col <= '0;
						gap <= '0;
						found <= 1'b0;
						state <= bsr_pkg::SCAN_SEEK;
					end
				end
				bsr_pkg::SCAN_SEEK, bsr_pkg::SCAN_TRACK, bsr_pkg::SCAN_CLOSED:
				begin
					if (state == bsr_pkg::SCAN_SEEK && cur_bit)
					begin
						found <= 1'b1;
						gap <= '0;
						state <= bsr_pkg::SCAN_TRACK;
					end
					else if (state == bsr_pkg::SCAN_TRACK)
					begin
						if (cur_bit)
							gap <= '0;
						else if (gap >= i_max_gap)
							state <= bsr_pkg::SCAN_CLOSED;
						else
							gap <= gap + 1'b1;
					end
					// last column overrides the phase change
					if (col == LAST_COL)
						state <= bsr_pkg::SCAN_MASK;
					else
						col <= col + 1'b1;
				end
				bsr_pkg::SCAN_MASK:
					state <= bsr_pkg::SCAN_OUT;
				bsr_pkg::SCAN_OUT:
				begin
					if (i_out_ready)
						state <= bsr_pkg::SCAN_IDLE;
				end
				default:
					state <= bsr_pkg::SCAN_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clk)
	begin
		case (state)
			bsr_pkg::SCAN_IDLE:
			begin
				if (i_row_valid)
				begin
					raw_row <= i_item.bits;
					// a new run starts from an all-ones mask
					filt_sr <= i_item.bits & (i_item.first ? ALL_ONES : prev_mask);
					cur_row <= i_item.row;
					cur_last <= i_item.last;
				end
			end
			bsr_pkg::SCAN_SEEK, bsr_pkg::SCAN_TRACK, bsr_pkg::SCAN_CLOSED:
			begin
				filt_sr <= filt_sr >> 1;
				if (cur_bit && state == bsr_pkg::SCAN_SEEK)
				begin
					left_b <= col;
					right_b <= col;
				end
				else if (cur_bit && state == bsr_pkg::SCAN_TRACK)
					right_b <= col;
			end
			bsr_pkg::SCAN_MASK:
			begin
				prev_mask <= new_mask;
				out_bits <= raw_row & new_mask;
			end
			default:
			begin
			end
		endcase
	end

	// ones from left through right, zero when nothing was seen
	always_comb
	begin
		new_mask = '0;
		if (found)
			new_mask = (ALL_ONES << left_b) & (ALL_ONES >> (`BSR_ROW_BITS - 1 - right_b));
	end

	assign o_row_ready = (state == bsr_pkg::SCAN_IDLE);
	assign o_out_valid = (state == bsr_pkg::SCAN_OUT);
	assign o_item = '{row: cur_row, last: cur_last, bits: out_bits};

endmodule

`default_nettype wire

//--- verilog/row_writeback.sv
`include "bsr_macros.svh"
`default_nettype none

module row_writeback (
	input wire logic i_clk,
	input wire logic i_rstn,
	input wire logic i_trig,
	input wire bsr_pkg::out_item_t i_item,
	input wire logic i_out_valid,
	output logic o_out_ready,
	output bsr_pkg::wb_req_t o_wb,
	input wire bsr_pkg::wb_rsp_t i_wb,
	output logic o_done
);

	localparam int WIDX_W = $clog2(`BSR_WORDS_PER_ROW);
	localparam logic [WIDX_W-1:0] LAST_WORD = WIDX_W'(`BSR_WORDS_PER_ROW - 1);

	bsr_pkg::wb_state_t state;
	logic [WIDX_W-1:0] word_cnt;
	logic done_r;

	bsr_pkg::row_bits_t wr_bits;
	bsr_pkg::row_num_t wr_row;
	logic wr_last;

	always_ff @(posedge i_clk or negedge i_rstn)
	begin
		if (!i_rstn)
		begin
			state <= bsr_pkg::WB_IDLE;
			word_cnt <= '0;
			done_r <= 1'b0;
		end
		else
		begin
			case (state)
				bsr_pkg::WB_IDLE:
				begin
					if (i_out_valid)
					begin
						word_cnt <= '0;
						state <= bsr_pkg::WB_WRITE;
					end
				end
				bsr_pkg::WB_WRITE:
				begin
					if (i_wb.ack)
					begin
						if (word_cnt == LAST_WORD)
							state <= bsr_pkg::WB_IDLE;
						else
							word_cnt <= word_cnt + 1'b1;
					end
				end
				default:
					state <= bsr_pkg::WB_IDLE;
			endcase

			// done holds until trig drops
			if (!i_trig)
				done_r <= 1'b0;
			else if (state == bsr_pkg::WB_WRITE && i_wb.ack && word_cnt == LAST_WORD
				&& wr_last)
				done_r <= 1'b1;
		end
	end

	always_ff @(posedge i_clk)
	begin
		if (state == bsr_pkg::WB_IDLE && i_out_valid)
		begin
			wr_bits <= i_item.bits;
			wr_row <= i_item.row;
			wr_last <= i_item.last;
		end
	end

	assign o_out_ready = (state == bsr_pkg::WB_IDLE);

	assign o_wb.cyc = (state == bsr_pkg::WB_WRITE);
	assign o_wb.stb = (state == bsr_pkg::WB_WRITE);
	assign o_wb.we = 1'b1;
	assign o_wb.adr = bsr_pkg::mem_addr_t'(wr_row * `BSR_WORDS_PER_ROW)
		+ bsr_pkg::mem_addr_t'(word_cnt);
	assign o_wb.dat = wr_bits[word_cnt*`BSR_WORD_BITS +: `BSR_WORD_BITS];

	assign o_done = done_r & i_trig;

endmodule

`default_nettype wire

//--- verilog/mem_bus_arbiter.sv
`default_nettype none

module mem_bus_arbiter (
	input wire logic i_clk,
	input wire logic i_rstn,
	input wire bsr_pkg::wb_req_t i_fetch_req,
	output bsr_pkg::wb_rsp_t o_fetch_rsp,
	input wire bsr_pkg::wb_req_t i_wr_req,
	output bsr_pkg::wb_rsp_t o_wr_rsp,
	output bsr_pkg::wb_req_t o_wb,
	input wire bsr_pkg::wb_rsp_t i_wb
);

	// gnt_wr picks the owner while gnt_valid is set
	logic gnt_valid;
	logic gnt_wr;

	always_ff @(posedge i_clk or negedge i_rstn)
	begin
		if (!i_rstn)
		begin
			gnt_valid <= 1'b0;
			gnt_wr <= 1'b0;
		end
		else if (!gnt_valid)
		begin
			// write-back first on a tie
			if (i_wr_req.cyc && i_wr_req.stb)
			begin
				gnt_valid <= 1'b1;
				gnt_wr <= 1'b1;
			end
			else if (i_fetch_req.cyc && i_fetch_req.stb)
			begin
				gnt_valid <= 1'b1;
				gnt_wr <= 1'b0;
			end
		end
		else if (i_wb.ack)
			gnt_valid <= 1'b0;
	end

	assign o_wb = !gnt_valid ? '0 : (gnt_wr ? i_wr_req : i_fetch_req);

	assign o_fetch_rsp.ack = gnt_valid && !gnt_wr && i_wb.ack;
	assign o_fetch_rsp.dat = i_wb.dat;
	assign o_wr_rsp.ack = gnt_valid && gnt_wr && i_wb.ack;
	assign o_wr_rsp.dat = i_wb.dat;

endmodule

`default_nettype wire

//--- verilog/boundary_search.sv
`default_nettype none

module boundary_search (
	input wire logic i_clk,
	input wire logic i_rstn,
	input wire logic i_trig,
	output logic o_done,
	input wire bsr_pkg::bsr_cfg_t i_cfg,
	output bsr_pkg::wb_req_t o_wb,
	input wire bsr_pkg::wb_rsp_t i_wb
);

	bsr_pkg::row_item_t row_item;
	logic row_valid;
	logic row_ready;

	bsr_pkg::out_item_t out_item;
	logic out_valid;
	logic out_ready;

	bsr_pkg::wb_req_t fetch_req;
	bsr_pkg::wb_rsp_t fetch_rsp;
	bsr_pkg::wb_req_t wr_req;
	bsr_pkg::wb_rsp_t wr_rsp;

	// stage 1, row reads
	row_fetch u_row_fetch (
		.i_clk(i_clk),
		.i_rstn(i_rstn),
		.i_trig(i_trig),
		.i_cfg(i_cfg),
		.o_item(row_item),
		.o_row_valid(row_valid),
		.i_row_ready(row_ready),
		.o_wb(fetch_req),
		.i_wb(fetch_rsp)
	);

	// stage 2, column scan and mask
	boundary_scan u_boundary_scan (
		.i_clk(i_clk),
		.i_rstn(i_rstn),
		.i_item(row_item),
		.i_row_valid(row_valid),
		.o_row_ready(row_ready),
		.i_max_gap(i_cfg.max_gap),
		.o_item(out_item),
		.o_out_valid(out_valid),
		.i_out_ready(out_ready)
	);

	// stage 3, masked row writes
	row_writeback u_row_writeback (
		.i_clk(i_clk),
		.i_rstn(i_rstn),
		.i_trig(i_trig),
		.i_item(out_item),
		.i_out_valid(out_valid),
		.o_out_ready(out_ready),
		.o_wb(wr_req),
		.i_wb(wr_rsp),
		.o_done(o_done)
	);

	mem_bus_arbiter u_mem_bus_arbiter (
		.i_clk(i_clk),
		.i_rstn(i_rstn),
		.i_fetch_req(fetch_req),
		.o_fetch_rsp(fetch_rsp),
		.i_wr_req(wr_req),
		.o_wr_rsp(wr_rsp),
		.o_wb(o_wb),
		.i_wb(i_wb)
	);

endmodule

`default_nettype wire

//--- testbench/boundary_search_assert.sv
`default_nettype none

module boundary_search_assert (
	input wire logic i_clk,
	input wire logic i_rstn,
	input wire logic i_trig,
	input wire logic o_done,
	input wire bsr_pkg::wb_req_t o_wb,
	input wire bsr_pkg::wb_rsp_t i_wb
);

	// strobe only inside a bus cycle
	stb_in_cyc: assert property (@(posedge i_clk) disable iff (!i_rstn)
		o_wb.stb |-> o_wb.cyc)
		else $error("wishbone stb high without cyc");

	// request held until the slave acks
	req_stable: assert property (@(posedge i_clk) disable iff (!i_rstn)
		(o_wb.stb && !i_wb.ack) |=> $stable(o_wb))
		else $error("wishbone request changed before ack");

	// done needs trig now and on the edge before, so a low trig clears it
	done_needs_trig: assert property (@(posedge i_clk) disable iff (!i_rstn)
		o_done |-> (i_trig && $past(i_trig)))
		else $error("o_done high while i_trig low or not yet held");

endmodule

bind boundary_search boundary_search_assert boundary_search_assert_inst (
	.i_clk(i_clk),
	.i_rstn(i_rstn),
	.i_trig(i_trig),
	.o_done(o_done),
	.o_wb(o_wb),
	.i_wb(i_wb)
);

`default_nettype wire

//--- testbench/boundary_search_tb.sv
`include "bsr_macros.svh"
`default_nettype none

module boundary_search_tb;

	localparam int MEM_WORDS = 128;
	localparam int WPR = `BSR_WORDS_PER_ROW;
	localparam int WB = `BSR_WORD_BITS;
	localparam int NUM_TESTS = 5;
	localparam int MAX_ROWS = 8;
	localparam int TIMEOUT_CYCLES = NUM_TESTS * MAX_ROWS * 200;

	logic i_clk;
	logic i_rstn;
	logic i_trig;
	logic o_done;
	bsr_pkg::bsr_cfg_t i_cfg;
	bsr_pkg::wb_req_t o_wb;
	bsr_pkg::wb_rsp_t i_wb;

	bsr_pkg::mem_word_t mem [MEM_WORDS];
	bsr_pkg::mem_word_t expect_mem [MEM_WORDS];
	bsr_pkg::mem_word_t seed_mem [MEM_WORDS];

	logic [15:0] lfsr;
	int wait_cnt;
	logic slave_busy;
	int write_cnt;
	int err_cnt;
	int tests_run;
	int tests_failed;
	int cmp_req;
	int cmp_ack;

	boundary_search boundary_search_inst (
		.i_clk(i_clk),
		.i_rstn(i_rstn),
		.i_trig(i_trig),
		.o_done(o_done),
		.i_cfg(i_cfg),
		.o_wb(o_wb),
		.i_wb(i_wb)
	);

	initial
	begin
		i_clk = 1'b0;
		forever #50 i_clk = ~i_clk;
	end

	// galois form, taps x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		lfsr_next = s >> 1;
		if (s[0])
			lfsr_next = lfsr_next ^ 16'hB400;
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			v[i] = lfsr[0];
			lfsr = lfsr_next(lfsr);
		end
	endtask

	// seek, track, closed over one filtered row
	function automatic bsr_pkg::row_bits_t ref_mask(input bsr_pkg::row_bits_t filt,
		input int max_gap);
		int left;
		int right;
		int gap;
		int phase;
		bsr_pkg::row_bits_t m;
		left = -1;
		right = -1;
		gap = 0;
		phase = 0;
		for (int c = 0; c < `BSR_ROW_BITS; c++)
		begin
			if (phase == 0 && filt[c])
			begin
				left = c;
				right = c;
				gap = 0;
				phase = 1;
			end
			else if (phase == 1)
			begin
				if (filt[c])
				begin
					right = c;
					gap = 0;
				end
				else
				begin
					gap++;
					if (gap > max_gap)
						phase = 2;
				end
			end
		end
		m = '0;
		if (left >= 0)
			for (int c = left; c <= right; c++)
				m[c] = 1'b1;
		return m;
	endfunction

	task automatic build_expected(input int first_row, input int last_row, input int max_gap);
		bsr_pkg::row_bits_t prev;
		bsr_pkg::row_bits_t raw;
		bsr_pkg::row_bits_t m;
		bsr_pkg::row_bits_t res;
		expect_mem = mem;
		prev = '1;
		for (int r = first_row; r <= last_row; r++)
		begin
			for (int k = 0; k < WPR; k++)
				raw[k*WB +: WB] = mem[r*WPR + k];
			m = ref_mask(raw & prev, max_gap);
			res = raw & m;
			for (int k = 0; k < WPR; k++)
				expect_mem[r*WPR + k] = res[k*WB +: WB];
			prev = m;
		end
	endtask

	task automatic log_failure(input string msg);
		$display("error at %0t: %s", $time, msg);
		err_cnt++;
	endtask

	task automatic compare_word(input int a, input bsr_pkg::mem_word_t exp);
		assert (mem[a] === exp)
		else
		begin
			$display("mismatch at %0t: mem[%0d] got %h expected %h", $time, a, mem[a], exp);
			err_cnt++;
		end
	endtask

	task automatic fill_random(input bit sparse);
		logic [31:0] a;
		logic [31:0] b;
		for (int i = 0; i < MEM_WORDS; i++)
		begin
			take_bits(32, a);
			if (sparse)
			begin
				take_bits(32, b);
				a = a & b;
			end
			mem[i] = a;
		end
	endtask

	task automatic finish_test(input string name, input int err_before);
		tests_run++;
		if (err_cnt == err_before)
			$display("test %s: pass", name);
		else
		begin
			tests_failed++;
			$display("test %s: fail, %0d errors", name, err_cnt - err_before);
		end
	endtask

	// one trig/done run, then a full memory compare
	task automatic run_once(input int first_row, input int last_row, input int max_gap,
		input int hold);
		int nrows;
		int cycles;
		nrows = last_row - first_row + 1;
		build_expected(first_row, last_row, max_gap);
		write_cnt = 0;
		@(negedge i_clk);
		assert (o_done === 1'b0) else log_failure("o_done high before the run started");
		i_cfg.first_row = bsr_pkg::row_num_t'(first_row);
		i_cfg.last_row = bsr_pkg::row_num_t'(last_row);
		i_cfg.max_gap = bsr_pkg::gap_t'(max_gap);
		i_trig = 1'b1;
		cycles = 0;
		while (o_done !== 1'b1 && cycles < nrows * 200)
		begin
			@(negedge i_clk);
			cycles++;
		end
		assert (o_done === 1'b1)
		else
			log_failure($sformatf("o_done did not rise within %0d cycles", nrows * 200));
		if (o_done === 1'b1)
		begin
			assert (write_cnt == nrows * WPR)
			else
				log_failure($sformatf("o_done rose after %0d of %0d word writes",
					write_cnt, nrows * WPR));
			repeat (hold)
			begin
				@(negedge i_clk);
				assert (o_done === 1'b1) else log_failure("o_done dropped while i_trig held");
			end
		end
		i_trig = 1'b0;
		@(negedge i_clk);
		assert (o_done === 1'b0) else log_failure("o_done stayed high after i_trig fell");
		cmp_req++;
		wait (cmp_ack == cmp_req);
	endtask

	// memory slave, 0 to 3 wait cycles per access
	initial
	begin
		logic [31:0] r;
		i_wb = '0;
		slave_busy = 1'b0;
		wait_cnt = 0;
		forever
		begin
			@(negedge i_clk);
			if (i_wb.ack)
				i_wb.ack = 1'b0;
			else if (o_wb.cyc && o_wb.stb)
			begin
				if (!slave_busy)
				begin
					take_bits(2, r);
					wait_cnt = int'(r[1:0]);
					slave_busy = 1'b1;
				end
				if (wait_cnt == 0)
				begin
					slave_busy = 1'b0;
					if (o_wb.we)
					begin
						mem[o_wb.adr] = o_wb.dat;
						write_cnt++;
					end
					else
						i_wb.dat = mem[o_wb.adr];
					i_wb.ack = 1'b1;
				end
				else
					wait_cnt--;
			end
		end
	end

	// compare process, covers rows in range and untouched words
	initial
	begin
		forever
		begin
			wait (cmp_req != cmp_ack);
			for (int a = 0; a < MEM_WORDS; a++)
				compare_word(a, expect_mem[a]);
			cmp_ack = cmp_req;
		end
	end

	initial
	begin
		repeat (TIMEOUT_CYCLES) @(posedge i_clk);
		$display("watchdog expired after %0d cycles, DUT stalled", TIMEOUT_CYCLES);
		$display("SIMULATION FAILED");
		$finish;
	end

	initial
	begin
		logic [31:0] v;
		int base;
		lfsr = 16'd61;
		i_rstn = 1'b0;
		i_trig = 1'b0;
		i_cfg = '0;
		repeat (10) @(negedge i_clk);
		i_rstn = 1'b1;

		// reset state, done level and a repeated start
		base = err_cnt;
		@(negedge i_clk);
		assert (o_done === 1'b0) else log_failure("o_done high after reset");
		assert (o_wb.cyc === 1'b0 && o_wb.stb === 1'b0)
		else
			log_failure("bus cycle active after reset");
		fill_random(1'b0);
		run_once(40, 42, 2, 4);
		run_once(40, 43, 5, 2);
		finish_test("handshake", base);

		base = err_cnt;
		fill_random(1'b0);
		take_bits(4, v);
		run_once(5, 5, int'(v[3:0]), 3);
		finish_test("single_row", base);

		base = err_cnt;
		fill_random(1'b1);
		run_once(10, 14, 3, 1);
		finish_test("five_rows", base);

		// row 22 empty, so the rest of the run clears
		base = err_cnt;
		fill_random(1'b1);
		mem[22*WPR] = '0;
		mem[22*WPR + 1] = '0;
		run_once(20, 25, 4, 1);
		for (int a = 22*WPR; a < 26*WPR; a++)
			compare_word(a, '0);
		finish_test("zero_row", base);

		base = err_cnt;
		fill_random(1'b1);
		seed_mem = mem;
		run_once(30, 33, 0, 1);
		mem = seed_mem;
		run_once(30, 33, 15, 1);
		finish_test("gap_limits", base);

		$display("tests %0d, passed %0d, failed %0d, errors %0d",
			tests_run, tests_run - tests_failed, tests_failed, err_cnt);
		if (err_cnt == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+verilog
verilog/bsr_pkg.sv
verilog/row_fetch.sv
verilog/boundary_scan.sv
verilog/row_writeback.sv
verilog/mem_bus_arbiter.sv
verilog/boundary_search.sv
testbench/boundary_search_assert.sv
testbench/boundary_search_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module boundary_search_tb -Mdir obj_dir -f vlog.f

out=$(./obj_dir/Vboundary_search_tb 2>&1) || true
echo "$out"

# the run passes only if the pass line was printed
echo "$out" | grep -q "^SIMULATION PASSED$"
